/* source/sync_cfg_pkg.sv */
package sync_cfg_pkg;

    ////////////////////
    // Datapath widths
    ////////////////////
    localparam int SAMPLE_W = 16;   // One real sample.
    localparam int METRIC_W = 32;   // Correlator metric.

    ////////////////////
    // Sync sequence
    ////////////////////
    localparam int PSS_LEN = 16;
    localparam logic [PSS_LEN-1:0] PSS_TAP_MASK = 16'hE6A1; // Set bit is +1.

    // Detector and tracking loop.
    localparam int WINDOW_LEN   = 8;    // Power of two.
    localparam int DETECT_SHIFT = 2;    // Threshold factor of 4.
    localparam int PERIOD_LEN   = 64;   // In decimated samples.
    localparam int PERIOD_TOL   = 2;
    localparam int MAX_MISSES   = 2;

endpackage

/* source/sync_types_pkg.sv */
package sync_types_pkg;

    import sync_cfg_pkg::*;

    ////////////////////
    // Sample stream
    ////////////////////
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // Q sits in the upper half of the word.
    typedef struct packed {
        sample_t q;
        sample_t i;
    } iq_t;

    typedef logic [METRIC_W-1:0] metric_t;  // Unsigned magnitude.

    ////////////////////
    // Controller
    ////////////////////
    typedef enum logic {
        SEARCH = 1'b0,  // Waiting for a first peak.
        TRACK  = 1'b1   // Locked to the period.
    } sync_state_e;

endpackage

/* source/sync_ctrl_if.sv */
interface sync_ctrl_if;

    logic detect_en;    // Level from the controller.
    logic peak;         // One-cycle pulse.
    logic timer_start;  // Restarts the count at zero.
    logic gate_open;    // Inside the expected-peak window.
    logic expired;      // Window passed without a peak.

    modport ctrl (output detect_en, output timer_start,
                  input  peak, input gate_open, input expired);
    modport det  (input  detect_en, output peak);
    modport tmr  (input  timer_start, output gate_open, output expired);

endinterface

/* source/cic_decimator.sv */
module cic_decimator
    import sync_types_pkg::*;
#(
    parameter int DATA_W = sync_cfg_pkg::SAMPLE_W
) (
    input  logic    clk_i,
    input  logic    rst_i,
    input  sample_t in_data_i,
    input  logic    in_valid_i,
    output sample_t out_data_o,
    output logic    out_valid_o
);

    localparam int ACC_W = DATA_W + 3;  // Gain of 8 for N=3, R=2.

    logic signed [ACC_W-1:0] integ1, integ2, integ3;
    logic signed [ACC_W-1:0] integ1_nxt, integ2_nxt, integ3_nxt;
    logic signed [ACC_W-1:0] comb1_dly, comb2_dly, comb3_dly;
    logic signed [ACC_W-1:0] comb1, comb2, comb3;
    logic                    phase;     // High on the sample that is kept.

    ////////////////////
    // Integrators, combs
    ////////////////////
    always_comb begin
        integ1_nxt = integ1 + ACC_W'(in_data_i);
        integ2_nxt = integ2 + integ1_nxt;
        integ3_nxt = integ3 + integ2_nxt;
        // Differential delay of one output sample.
        comb1 = integ3_nxt - comb1_dly;
        comb2 = comb1 - comb2_dly;
        comb3 = comb2 - comb3_dly;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            integ1      <= '0;
            integ2      <= '0;
            integ3      <= '0;
            comb1_dly   <= '0;
            comb2_dly   <= '0;
            comb3_dly   <= '0;
            phase       <= 1'b0;
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= 1'b0;
            if (in_valid_i) begin
                integ1 <= integ1_nxt;
                integ2 <= integ2_nxt;
                integ3 <= integ3_nxt;
                phase  <= ~phase;
                if (phase) begin
                    comb1_dly   <= integ3_nxt;
                    comb2_dly   <= comb1;
                    comb3_dly   <= comb2;
                    out_valid_o <= 1'b1;
                end
            end
        end
    end

    // Divide by the gain of 8.
    always_ff @(posedge clk_i) begin
        if (in_valid_i && phase) begin
            out_data_o <= comb3[ACC_W-1:3];
        end
    end

endmodule

/* source/pss_correlator.sv */
module pss_correlator
    import sync_types_pkg::*;
#(
    parameter int                 PSS_LEN  = sync_cfg_pkg::PSS_LEN,
    parameter logic [PSS_LEN-1:0] TAP_MASK = sync_cfg_pkg::PSS_TAP_MASK
) (
    input  logic    clk_i,
    input  logic    rst_i,
    input  iq_t     in_data_i,
    input  logic    in_valid_i,
    output metric_t metric_o,
    output logic    metric_valid_o
);

    // Room for PSS_LEN full-scale samples of either sign.
    localparam int ACC_W = $bits(sample_t) + $clog2(PSS_LEN) + 1;

    sample_t                 hist_i [PSS_LEN-1];
    sample_t                 hist_q [PSS_LEN-1];
    sample_t                 win_i  [PSS_LEN];
    sample_t                 win_q  [PSS_LEN];
    logic signed [ACC_W-1:0] sum_i, sum_q;
    logic signed [ACC_W-1:0] acc_i, acc_q;
    logic        [ACC_W-1:0] abs_i, abs_q;
    logic                    stage1_valid;

    // Newest sample is tap 0.
    always_comb begin
        win_i[0] = in_data_i.i;
        win_q[0] = in_data_i.q;
        for (int k = 1; k < PSS_LEN; k++) begin
            win_i[k] = hist_i[k-1];
            win_q[k] = hist_q[k-1];
        end
    end

    always_comb begin
        sum_i = '0;
        sum_q = '0;
        for (int k = 0; k < PSS_LEN; k++) begin
            if (TAP_MASK[k]) begin
                sum_i = sum_i + win_i[k];
                sum_q = sum_q + win_q[k];
            end else begin
                sum_i = sum_i - win_i[k];
                sum_q = sum_q - win_q[k];
            end
        end
    end

    ////////////////////
    // Stage one
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int k = 0; k < PSS_LEN - 1; k++) begin
                hist_i[k] <= '0;
                hist_q[k] <= '0;
            end
            stage1_valid <= 1'b0;
        end else begin
            stage1_valid <= in_valid_i;
            if (in_valid_i) begin
                hist_i[0] <= in_data_i.i;
                hist_q[0] <= in_data_i.q;
                for (int k = 1; k < PSS_LEN - 1; k++) begin
                    hist_i[k] <= hist_i[k-1];
                    hist_q[k] <= hist_q[k-1];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i) begin
            acc_i <= sum_i;
            acc_q <= sum_q;
        end
    end

    ////////////////////
    // Stage two
    ////////////////////
    assign abs_i = acc_i[ACC_W-1] ? -acc_i : acc_i;
    assign abs_q = acc_q[ACC_W-1] ? -acc_q : acc_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            metric_valid_o <= 1'b0;
        end else begin
            metric_valid_o <= stage1_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (stage1_valid) begin
            metric_o <= metric_t'(abs_i) + metric_t'(abs_q);
        end
    end

endmodule

/* source/peak_detector.sv */
module peak_detector
    import sync_types_pkg::*;
#(
    parameter int WINDOW_LEN   = sync_cfg_pkg::WINDOW_LEN,
    parameter int DETECT_SHIFT = sync_cfg_pkg::DETECT_SHIFT
) (
    input  logic     clk_i,
    input  logic     rst_i,
    input  metric_t  metric_i,
    input  logic     metric_valid_i,
    input  metric_t  noise_limit_i,
    sync_ctrl_if.det ctrl
);

    localparam int WIN_AW = $clog2(WINDOW_LEN);
    localparam int SUM_W  = $bits(metric_t) + WIN_AW;
    localparam int THR_W  = $bits(metric_t) + DETECT_SHIFT;

    metric_t           win_buf [WINDOW_LEN];
    logic [WIN_AW-1:0] wr_ptr;      // Oldest entry once full.
    logic [WIN_AW:0]   fill_cnt;
    logic [SUM_W-1:0]  win_sum;
    metric_t           average;
    logic [THR_W-1:0]  threshold;
    logic              win_full;
    logic              hit;

    assign win_full  = (fill_cnt == (WIN_AW + 1)'(WINDOW_LEN));
    assign average   = metric_t'(win_sum >> WIN_AW);
    assign threshold = THR_W'(average) << DETECT_SHIFT;

    // Current metric is not part of its own average.
    assign hit = ctrl.detect_en && win_full
              && (metric_i > noise_limit_i)
              && (THR_W'(metric_i) > threshold);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr    <= '0;
            fill_cnt  <= '0;
            win_sum   <= '0;
            ctrl.peak <= 1'b0;
        end else begin
            ctrl.peak <= metric_valid_i && hit;
            if (metric_valid_i) begin
                wr_ptr <= wr_ptr + 1'b1;
                if (win_full) begin
                    win_sum <= win_sum - SUM_W'(win_buf[wr_ptr]) + SUM_W'(metric_i);
                end else begin
                    win_sum  <= win_sum + SUM_W'(metric_i);
                    fill_cnt <= fill_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (metric_valid_i) begin
            win_buf[wr_ptr] <= metric_i;
        end
    end

endmodule

/* source/period_timer.sv */
module period_timer #(
    parameter int PERIOD_LEN = sync_cfg_pkg::PERIOD_LEN,
    parameter int PERIOD_TOL = sync_cfg_pkg::PERIOD_TOL
) (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     tick_i,
    sync_ctrl_if.tmr ctrl
);

    localparam int GATE_LO = PERIOD_LEN - PERIOD_TOL;
    localparam int GATE_HI = PERIOD_LEN + PERIOD_TOL;
    localparam int CNT_W   = $clog2(GATE_HI + 1);

    logic [CNT_W-1:0] count;
    logic             running;

    assign ctrl.gate_open = running && (count >= CNT_W'(GATE_LO))
                         && (count <= CNT_W'(GATE_HI));

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            count        <= '0;
            running      <= 1'b0;
            ctrl.expired <= 1'b0;
        end else begin
            ctrl.expired <= 1'b0;
            if (ctrl.timer_start) begin
                count   <= '0;
                running <= 1'b1;
            end else if (running && tick_i) begin
                if (count == CNT_W'(GATE_HI)) begin
                    running      <= 1'b0;   // Idle until restarted.
                    ctrl.expired <= 1'b1;
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

endmodule

/* source/sync_fsm.sv */
module sync_fsm
    import sync_types_pkg::*;
#(
    parameter int MAX_MISSES = sync_cfg_pkg::MAX_MISSES
) (
    input  logic      clk_i,
    input  logic      rst_i,
    sync_ctrl_if.ctrl ctrl,
    output logic      peak_detected_o,
    output logic      locked_o
);

    localparam int MISS_W = $clog2(MAX_MISSES + 1);

    sync_state_e       state;
    logic [MISS_W-1:0] misses;

    // While tracking, only peaks inside the gate count.
    assign ctrl.detect_en   = (state == SEARCH) ? 1'b1 : ctrl.gate_open;
    assign locked_o         = (state == TRACK);
    assign peak_detected_o  = ctrl.peak;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state            <= SEARCH;
            misses           <= '0;
            ctrl.timer_start <= 1'b0;
        end else begin
            ctrl.timer_start <= 1'b0;
            case (state)
                SEARCH: begin
                    if (ctrl.peak) begin
                        state            <= TRACK;
                        misses           <= '0;
                        ctrl.timer_start <= 1'b1;
                    end
                end
                TRACK: begin
                    if (ctrl.peak) begin
                        misses           <= '0;
                        ctrl.timer_start <= 1'b1;
                    end else if (ctrl.expired) begin
                        if (misses == MISS_W'(MAX_MISSES - 1)) begin
                            state  <= SEARCH;   // Lock lost.
                            misses <= '0;
                        end else begin
                            misses           <= misses + 1'b1;
                            ctrl.timer_start <= 1'b1;
                        end
                    end
                end
                default: state <= SEARCH;
            endcase
        end
    end

endmodule

/* source/pss_sync_top.sv */
module pss_sync_top
    import sync_types_pkg::*;
#(
    parameter int                 DATA_W       = sync_cfg_pkg::SAMPLE_W,
    parameter int                 PSS_LEN      = sync_cfg_pkg::PSS_LEN,
    parameter logic [PSS_LEN-1:0] TAP_MASK     = sync_cfg_pkg::PSS_TAP_MASK,
    parameter int                 WINDOW_LEN   = sync_cfg_pkg::WINDOW_LEN,
    parameter int                 DETECT_SHIFT = sync_cfg_pkg::DETECT_SHIFT,
    parameter int                 PERIOD_LEN   = sync_cfg_pkg::PERIOD_LEN,
    parameter int                 PERIOD_TOL   = sync_cfg_pkg::PERIOD_TOL,
    parameter int                 MAX_MISSES   = sync_cfg_pkg::MAX_MISSES
) (
    input  logic    clk_i,
    input  logic    rst_i,
    input  iq_t     in_data_i,
    input  logic    in_valid_i,
    input  metric_t noise_limit_i,
    output iq_t     dec_data_o,
    output logic    dec_valid_o,
    output metric_t metric_o,
    output logic    metric_valid_o,
    output logic    peak_detected_o,
    output logic    locked_o
);

    sample_t dec_i, dec_q;

    sync_ctrl_if ctrl_bus ();

    ////////////////////
    // Decimation
    ////////////////////
    cic_decimator #(.DATA_W(DATA_W)) u_cic_i (
        .clk_i, .rst_i, .in_data_i(in_data_i.i), .in_valid_i,
        .out_data_o(dec_i), .out_valid_o(dec_valid_o)
    );

    // Same strobe as the I channel.
    cic_decimator #(.DATA_W(DATA_W)) u_cic_q (
        .clk_i, .rst_i, .in_data_i(in_data_i.q), .in_valid_i,
        .out_data_o(dec_q), .out_valid_o()
    );

    assign dec_data_o.i = dec_i;
    assign dec_data_o.q = dec_q;

    ////////////////////
    // Detection and lock
    ////////////////////
    pss_correlator #(.PSS_LEN(PSS_LEN), .TAP_MASK(TAP_MASK)) u_corr (
        .clk_i, .rst_i, .in_data_i(dec_data_o), .in_valid_i(dec_valid_o),
        .metric_o, .metric_valid_o
    );

    peak_detector #(.WINDOW_LEN(WINDOW_LEN), .DETECT_SHIFT(DETECT_SHIFT)) u_det (
        .clk_i, .rst_i, .metric_i(metric_o), .metric_valid_i(metric_valid_o),
        .noise_limit_i, .ctrl(ctrl_bus)
    );

    period_timer #(.PERIOD_LEN(PERIOD_LEN), .PERIOD_TOL(PERIOD_TOL)) u_tmr (
        .clk_i, .rst_i, .tick_i(dec_valid_o), .ctrl(ctrl_bus)
    );

    sync_fsm #(.MAX_MISSES(MAX_MISSES)) u_fsm (
        .clk_i, .rst_i, .ctrl(ctrl_bus), .peak_detected_o, .locked_o
    );

endmodule

/* tests/sync_ref_model.svh */
`ifndef SYNC_REF_MODEL_SVH
`define SYNC_REF_MODEL_SVH

localparam int MAX_CYC = 8192;
localparam int GATE_LO = PERIOD_LEN - PERIOD_TOL;
localparam int GATE_HI = PERIOD_LEN + PERIOD_TOL;

int          cic_hist  [2][4];          // Newest accepted input at index 0.
bit          cic_phase;
int          corr_hist [2][PSS_LEN];
longint      win_buf   [WINDOW_LEN];
int          win_cnt;
int          win_ptr;
longint      win_sum;
sync_state_e m_state = SEARCH;
int          m_misses;
bit          m_peak;
bit          m_expired;
bit          m_tstart;
bit          m_run;
int          m_cnt;

// Expected stream outputs, indexed by the cycle in which they are visible.
bit      exp_dec_v [MAX_CYC];
iq_t     exp_dec   [MAX_CYC];
bit      exp_met_v [MAX_CYC];
metric_t exp_met   [MAX_CYC];

// Third order CIC at rate 2 has the taps 1, 3, 3, 1.
function automatic sample_t cic_filter(int ch, int x);
    int sum;
    for (int n = 3; n > 0; n--) begin
        cic_hist[ch][n] = cic_hist[ch][n-1];
    end
    cic_hist[ch][0] = x;
    sum = cic_hist[ch][0] + 3 * cic_hist[ch][1] + 3 * cic_hist[ch][2] + cic_hist[ch][3];
    return sample_t'(sum >>> 3);
endfunction

function automatic int corr_abs(int ch, sample_t d);
    int acc;
    for (int k = PSS_LEN - 1; k > 0; k--) begin
        corr_hist[ch][k] = corr_hist[ch][k-1];
    end
    corr_hist[ch][0] = d;
    acc = 0;
    for (int k = 0; k < PSS_LEN; k++) begin
        acc = PSS_TAP_MASK[k] ? acc + corr_hist[ch][k] : acc - corr_hist[ch][k];
    end
    return (acc < 0) ? -acc : acc;
endfunction

// Input visible in cycle t, taken by the DUT at the next edge.
task automatic model_input(int t, iq_t s);
    sample_t yi;
    sample_t yq;
    yi = cic_filter(0, s.i);
    yq = cic_filter(1, s.q);
    if (cic_phase) begin
        exp_dec_v[t+1]   = 1'b1;
        exp_dec[t+1].i   = yi;
        exp_dec[t+1].q   = yq;
        exp_met_v[t+3]   = 1'b1;
        exp_met[t+3]     = metric_t'(corr_abs(0, yi) + corr_abs(1, yq));
    end
    cic_phase = !cic_phase;
endtask

// Control state visible in cycle k, from what was visible in cycle k-1.
task automatic model_clock(int k, metric_t limit);
    bit     det_en;
    bit     nxt_peak;
    bit     nxt_exp;
    bit     nxt_start;
    longint met;
    longint thr;
    det_en    = (m_state == SEARCH) || (m_run && m_cnt >= GATE_LO && m_cnt <= GATE_HI);
    nxt_peak  = 1'b0;
    nxt_exp   = 1'b0;
    nxt_start = 1'b0;
    if (exp_met_v[k-1]) begin
        met      = exp_met[k-1];
        thr      = (win_sum >> 3) << DETECT_SHIFT;  // Previous metrics only.
        nxt_peak = det_en && win_cnt >= WINDOW_LEN && met > limit && met > thr;
        if (win_cnt == WINDOW_LEN) begin
            win_sum = win_sum - win_buf[win_ptr];
        end else begin
            win_cnt++;
        end
        win_sum          = win_sum + met;
        win_buf[win_ptr] = met;
        win_ptr          = (win_ptr + 1) % WINDOW_LEN;
    end
    if (m_tstart) begin
        m_cnt = 0;
        m_run = 1'b1;
    end else if (m_run && exp_dec_v[k-1]) begin
        if (m_cnt == GATE_HI) begin
            m_run   = 1'b0;
            nxt_exp = 1'b1;
        end else begin
            m_cnt++;
        end
    end
    if (m_state == SEARCH) begin
        if (m_peak) begin
            m_state   = TRACK;
            m_misses  = 0;
            nxt_start = 1'b1;
        end
    end else if (m_peak) begin
        m_misses  = 0;
        nxt_start = 1'b1;
    end else if (m_expired) begin
        if (m_misses + 1 >= MAX_MISSES) begin
            m_state  = SEARCH;  // Lock lost.
            m_misses = 0;
        end else begin
            m_misses++;
            nxt_start = 1'b1;
        end
    end
    m_peak    = nxt_peak;
    m_expired = nxt_exp;
    m_tstart  = nxt_start;
endtask

`endif

/* tests/tb_pss_sync.sv */
module tb_pss_sync
    import sync_cfg_pkg::*, sync_types_pkg::*;
();

    localparam metric_t NOISE_LIMIT = 32'd1500;

    logic    clk_i = 1'b0;
    logic    rst_i = 1'b1;
    iq_t     in_data_i = '0;
    logic    in_valid_i = 1'b0;
    metric_t noise_limit_i = NOISE_LIMIT;
    iq_t     dec_data_o;
    logic    dec_valid_o;
    metric_t metric_o;
    logic    metric_valid_o;
    logic    peak_detected_o;
    logic    locked_o;

    logic [39:0] stim_mem [64];     // Kind, length, amplitude, lock flag.
    int          cyc;
    bit          checking;
    int          tick_cnt;
    int          tick_limit;

    `include "sync_ref_model.svh"

    always #50 clk_i = ~clk_i;

    pss_sync_top #(
        .PSS_LEN(PSS_LEN), .TAP_MASK(PSS_TAP_MASK), .WINDOW_LEN(WINDOW_LEN),
        .DETECT_SHIFT(DETECT_SHIFT), .PERIOD_LEN(PERIOD_LEN),
        .PERIOD_TOL(PERIOD_TOL), .MAX_MISSES(MAX_MISSES)
    ) u_dut (
        .clk_i, .rst_i, .in_data_i, .in_valid_i, .noise_limit_i,
        .dec_data_o, .dec_valid_o, .metric_o, .metric_valid_o,
        .peak_detected_o, .locked_o
    );

    task automatic stop_run();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_iq(string name, iq_t act, iq_t exp);
        if (act !== exp) begin
            $display("MISMATCH %s: actual %h expected %h", name, act, exp);
            stop_run();
        end
    endtask

    task automatic check_metric(string name, metric_t act, metric_t exp);
        if (act !== exp) begin
            $display("MISMATCH %s: actual %h expected %h", name, act, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(string name, logic act, logic exp);
        if (act !== exp) begin
            $display("MISMATCH %s: actual %h expected %h", name, act, exp);
            stop_run();
        end
    endtask

    function automatic sample_t make_sample(int kind, int amp, int idx);
        int k;
        case (kind)
            1: return sample_t'(int'($urandom % (2 * amp + 1)) - amp);
            2: begin
                k = PSS_LEN - 1 - (idx / 2) % PSS_LEN;  // Tap 0 arrives last.
                return PSS_TAP_MASK[k] ? sample_t'(amp) : sample_t'(-amp);
            end
            default: return '0;
        endcase
    endfunction

    // Outputs are compared half a cycle after the edge.
    always @(negedge clk_i) begin
        if (checking) begin
            if (dec_valid_o !== exp_dec_v[cyc]) begin
                $display("dec_valid_o is wrong in cycle %0d, a valid is missing or extra", cyc);
                stop_run();
            end
            if (metric_valid_o !== exp_met_v[cyc]) begin
                $display("metric_valid_o is wrong in cycle %0d, a valid is missing or extra", cyc);
                stop_run();
            end
            if (exp_dec_v[cyc]) begin
                check_iq("dec_data_o", dec_data_o, exp_dec[cyc]);
            end
            if (exp_met_v[cyc]) begin
                check_metric("metric_o", metric_o, exp_met[cyc]);
            end
            check_bit("peak_detected_o", peak_detected_o, m_peak);
            check_bit("locked_o", locked_o, m_state == TRACK);
        end
    end

    always @(posedge clk_i) begin
        tick_cnt++;
        if (tick_limit > 0 && tick_cnt > tick_limit) begin
            $display("The run took longer than %0d cycles and was stopped", tick_limit);
            stop_run();
        end
    end

    initial begin
        int   nseg;
        int   total;
        int   kind;
        int   len;
        int   amp;
        logic lock_flag;
        iq_t  s;
        void'($urandom(32'h1dfe_999c));
        for (int n = 0; n < 64; n++) begin
            stim_mem[n] = '0;
        end
        $readmemh("tests/sync_stim.txt", stim_mem);
        nseg  = 0;
        total = 0;
        while (nseg < 64 && stim_mem[nseg][39:36] != 4'h0) begin
            total += int'(stim_mem[nseg][35:20]);
            nseg++;
        end
        if (nseg == 0) begin
            $display("The stimulus file holds no segments");
            stop_run();
        end
        tick_limit = 3 * total + 200;

        repeat (16) @(posedge clk_i);
        rst_i    <= 1'b0;
        cyc      = 0;
        checking = 1'b1;

        for (int seg = 0; seg < nseg; seg++) begin
            kind      = int'(stim_mem[seg][39:36]);
            len       = int'(stim_mem[seg][35:20]);
            amp       = int'(stim_mem[seg][19:4]);
            lock_flag = stim_mem[seg][0];
            for (int j = 0; j < len; j++) begin
                @(posedge clk_i);
                cyc++;
                model_clock(cyc, NOISE_LIMIT);
                s.i = make_sample(kind, amp, j);
                s.q = (kind == 2) ? s.i : make_sample(kind, amp, j);
                in_data_i  <= s;
                in_valid_i <= 1'b1;
                model_input(cyc, s);
            end
            check_bit("segment lock flag", m_state == TRACK, lock_flag);
        end

        // Let the pipeline drain.
        repeat (8) begin
            @(posedge clk_i);
            cyc++;
            model_clock(cyc, NOISE_LIMIT);
            in_valid_i <= 1'b0;
            in_data_i  <= '0;
        end
        @(posedge clk_i);
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* tests/sync_stim.txt */
// Columns kind_length_amplitude_lock, all hex. Kind 1 noise, 2 pss, 3 gap.
// Length in input samples, lock is the expected lock at segment end.
1_00C8_0028_0
2_0020_0028_0
1_0064_0028_0
3_0040_0000_0
2_0020_07D0_1
3_0060_0000_1
2_0020_07D0_1
3_0060_0000_1
2_0020_07D0_1
3_0060_0000_1
3_0040_0000_1
3_00C8_0000_0
1_0064_0028_0

/* files.f */
source/sync_cfg_pkg.sv
source/sync_types_pkg.sv
source/sync_ctrl_if.sv
source/cic_decimator.sv
source/pss_correlator.sv
source/peak_detector.sv
source/period_timer.sv
source/sync_fsm.sv
source/pss_sync_top.sv
+incdir+tests
tests/tb_pss_sync.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_pss_sync
OBJ_DIR   ?= obj_dir
FILELIST  ?= files.f
VFLAGS    ?= --binary -Wno-fatal
PASS_MSG  ?= Finished with no errors

SOURCES := $(wildcard source/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
